// ==== Makefile ====
# Verilator build and run of the SPI master testbench

VERILATOR ?= verilator
TOP       ?= spi_wb8_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the run passes only when the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF -- '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
hdl/spi_wb_pkg.sv
hdl/spi_wb_regs.sv
hdl/spi_tx_fifo.sv
hdl/spi_shift_engine.sv
hdl/spi_wb8.sv
sim/spi_wb8_properties.sv
sim/spi_wb8_tb.sv

// ==== hdl/spi_shift_engine.sv ====
`include "spi_wb_params.svh"

module spi_shift_engine (
    input  logic                  I_wb_clk,
    input  logic                  rst_n,
    input  logic                  empty,
    input  spi_wb_pkg::spi_byte_t pop_data,
    input  logic                  spi_miso,
    output logic                  pop,
    output logic                  busy,
    output logic                  rx_valid,
    output spi_wb_pkg::spi_byte_t rx_data,
    output logic                  spi_sclk,
    output logic                  spi_mosi
);

    localparam int DIV_W = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);

    logic                  active;
    logic [DIV_W-1:0]      div_cnt;
    logic [2:0]            bit_cnt;
    logic                  half_done;
    spi_wb_pkg::spi_byte_t tx_sr;
    spi_wb_pkg::spi_byte_t rx_sr;

    // a new byte waits one cycle after rx_valid
    assign pop       = ~active & ~rx_valid & ~empty;
    assign busy      = active | pop;
    assign half_done = (div_cnt == DIV_LAST);

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            spi_sclk <= 1'b0;
            spi_mosi <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (pop) begin
                active   <= 1'b1;
                div_cnt  <= '0;
                bit_cnt  <= '0;
                spi_sclk <= 1'b0;
                // msb goes out before the first rising edge
                spi_mosi <= pop_data[7];
            end else if (active) begin
                div_cnt <= half_done ? '0 : div_cnt + 1'b1;
                if (half_done) begin
                    spi_sclk <= ~spi_sclk;
                    if (spi_sclk) begin
                        // falling edge ends the bit
                        if (bit_cnt == 3'd7) begin
                            active   <= 1'b0;
                            rx_valid <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            spi_mosi <= tx_sr[6];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (pop) begin
            tx_sr <= pop_data;
        end else if (active && half_done) begin
            if (!spi_sclk) begin
                // sample on the rising edge
                rx_sr <= {rx_sr[6:0], spi_miso};
            end else begin
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (active && half_done && spi_sclk && (bit_cnt == 3'd7)) begin
            rx_data <= rx_sr;
        end
    end

endmodule

// ==== hdl/spi_tx_fifo.sv ====
`include "spi_wb_params.svh"

module spi_tx_fifo (
    input  logic                  I_wb_clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  spi_wb_pkg::spi_byte_t push_data,
    input  logic                  pop,
    output spi_wb_pkg::spi_byte_t pop_data,
    output logic                  empty,
    output logic                  full
);

    spi_wb_pkg::spi_byte_t mem [`SPI_TX_DEPTH];

    logic [`SPI_TX_PTR_W-1:0] wr_ptr;
    logic [`SPI_TX_PTR_W-1:0] rd_ptr;
    // one bit wider than the pointers so a full buffer can be told from an empty one
    logic [`SPI_TX_PTR_W:0]   count;

    assign empty    = (count == '0);
    assign full     = (count == (`SPI_TX_PTR_W+1)'(`SPI_TX_DEPTH));
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== hdl/spi_wb8.sv ====
module spi_wb8 (
    input  logic                  I_wb_clk,
    input  logic                  rst_n,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  spi_wb_pkg::spi_reg_e  wb_adr,
    input  spi_wb_pkg::spi_byte_t wb_wdata,
    output spi_wb_pkg::spi_byte_t wb_rdata,
    output logic                  wb_ack,
    input  logic                  spi_miso,
    output logic                  spi_sclk,
    output logic                  spi_mosi,
    output logic [2:0]            spi_cs_n
);

    logic                  push;
    spi_wb_pkg::spi_byte_t push_data;
    logic                  pop;
    spi_wb_pkg::spi_byte_t pop_data;
    logic                  empty;
    logic                  full;
    logic                  busy;
    logic                  rx_valid;
    spi_wb_pkg::spi_byte_t rx_data;

    spi_wb_regs u_regs (
        .I_wb_clk  (I_wb_clk),
        .rst_n     (rst_n),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .full      (full),
        .empty     (empty),
        .busy      (busy),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .wb_ack    (wb_ack),
        .wb_rdata  (wb_rdata),
        .push      (push),
        .push_data (push_data),
        .spi_cs_n  (spi_cs_n)
    );

    spi_tx_fifo u_tx_fifo (
        .I_wb_clk  (I_wb_clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full)
    );

    // engine pulls bytes from the buffer on its own while chip select stays with software
    spi_shift_engine u_engine (
        .I_wb_clk (I_wb_clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .pop_data (pop_data),
        .spi_miso (spi_miso),
        .pop      (pop),
        .busy     (busy),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi)
    );

endmodule

// ==== hdl/spi_wb_pkg.sv ====
package spi_wb_pkg;

    // data byte on the bus, in the buffer and in both shift registers
    typedef logic [7:0] spi_byte_t;

    // chip-select code where 0 selects nothing and 1 to 3 select device 1 to 3
    typedef logic [1:0] spi_cs_t;

    // register map with address 3 reading as status too
    typedef enum logic [1:0] {
        SPI_REG_DATA   = 2'd0,
        SPI_REG_CS     = 2'd1,
        SPI_REG_STATUS = 2'd2
    } spi_reg_e;

    // status word bits
    //   bit 0 is idle (buffer empty and engine not shifting)
    //   bit 1 is full (transmit buffer cannot take another byte)
    localparam int SPI_STAT_IDLE = 0;
    localparam int SPI_STAT_FULL = 1;

endpackage

// ==== hdl/spi_wb_regs.sv ====
module spi_wb_regs (
    input  logic                  I_wb_clk,
    input  logic                  rst_n,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  spi_wb_pkg::spi_reg_e  wb_adr,
    input  spi_wb_pkg::spi_byte_t wb_wdata,
    input  logic                  full,
    input  logic                  empty,
    input  logic                  busy,
    input  logic                  rx_valid,
    input  spi_wb_pkg::spi_byte_t rx_data,
    output logic                  wb_ack,
    output spi_wb_pkg::spi_byte_t wb_rdata,
    output logic                  push,
    output spi_wb_pkg::spi_byte_t push_data,
    output logic [2:0]            spi_cs_n
);

    spi_wb_pkg::spi_cs_t   cs_q;
    spi_wb_pkg::spi_byte_t rx_byte_q;
    spi_wb_pkg::spi_byte_t status;
    logic                  wr_stb;
    logic                  rd_stb;

    assign wr_stb = wb_stb & wb_we;
    assign rd_stb = wb_stb & ~wb_we;

    always_comb begin
        status = '0;
        status[spi_wb_pkg::SPI_STAT_IDLE] = empty & ~busy;
        status[spi_wb_pkg::SPI_STAT_FULL] = full;
    end

    // ack, push strobe and chip select
    always_ff @(posedge I_wb_clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            push     <= 1'b0;
            cs_q     <= '0;
            spi_cs_n <= 3'b111;
        end else begin
            wb_ack <= wb_stb;
            // writes while the buffer is full are lost
            push   <= wr_stb && (wb_adr == spi_wb_pkg::SPI_REG_DATA) && !full;
            if (wr_stb && (wb_adr == spi_wb_pkg::SPI_REG_CS)) begin
                cs_q <= spi_wb_pkg::spi_cs_t'(wb_wdata[1:0]);
            end
            // at most one active-low select
            case (cs_q)
                2'd1:    spi_cs_n <= 3'b110;
                2'd2:    spi_cs_n <= 3'b101;
                2'd3:    spi_cs_n <= 3'b011;
                default: spi_cs_n <= 3'b111;
            endcase
        end
    end

    always_ff @(posedge I_wb_clk) begin
        if (wr_stb && (wb_adr == spi_wb_pkg::SPI_REG_DATA)) begin
            push_data <= wb_wdata;
        end
    end

    // last byte shifted in from miso
    always_ff @(posedge I_wb_clk) begin
        if (rx_valid) begin
            rx_byte_q <= rx_data;
        end
    end

    // read data lines up with the ack
    always_ff @(posedge I_wb_clk) begin
        if (rd_stb) begin
            case (wb_adr)
                spi_wb_pkg::SPI_REG_DATA: wb_rdata <= rx_byte_q;
                spi_wb_pkg::SPI_REG_CS:   wb_rdata <= {6'b0, cs_q};
                default:                  wb_rdata <= status;
            endcase
        end
    end

endmodule

// ==== include/spi_wb_params.svh ====
`ifndef SPI_WB_PARAMS_SVH
`define SPI_WB_PARAMS_SVH

// transmit buffer

// bytes held by the transmit buffer (a power of two)
`define SPI_TX_DEPTH 4

// pointer width is log2 of SPI_TX_DEPTH
`define SPI_TX_PTR_W 2

// SPI clock

// half period of sclk in I_wb_clk cycles
// one byte takes 16 * SPI_CLK_DIV cycles
`define SPI_CLK_DIV 2

`endif

// ==== sim/spi_wb8_properties.sv ====
module spi_wb8_properties (
    input logic       I_wb_clk,
    input logic       rst_n,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic [2:0] spi_cs_n,
    input logic       spi_sclk,
    input logic       spi_mosi,
    input logic       empty,
    input logic       busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // ack is the strobe delayed by one cycle
    ack_follows_stb: assert property (@(posedge I_wb_clk) disable iff (!rst_n)
        wb_ack == $past(wb_stb))
        else $error("wb_ack does not follow wb_stb by one cycle");

    one_select: assert property (@(posedge I_wb_clk) disable iff (!rst_n)
        $onehot0(~spi_cs_n))
        else $error("more than one spi_cs_n bit is low");

    // in mode 0 data only changes while sclk is low
    mosi_stable_high: assert property (@(posedge I_wb_clk) disable iff (!rst_n)
        spi_sclk |-> $stable(spi_mosi))
        else $error("spi_mosi changed while spi_sclk was high");

    sclk_low_idle: assert property (@(posedge I_wb_clk) disable iff (!rst_n)
        (empty && !busy) |-> !spi_sclk)
        else $error("spi_sclk high while the engine is idle");

endmodule

bind spi_wb8 spi_wb8_properties u_props (
    .I_wb_clk (I_wb_clk),
    .rst_n    (rst_n),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .spi_cs_n (spi_cs_n),
    .spi_sclk (spi_sclk),
    .spi_mosi (spi_mosi),
    .empty    (empty),
    .busy     (busy)
);

// ==== sim/spi_wb8_tb.sv ====
`include "spi_wb_params.svh"

module spi_wb8_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_BYTES    = 17;
    localparam int TIMEOUT_NS = (N_BYTES + 8) * (16 * `SPI_CLK_DIV + 4) * 4 + 2000;
    localparam int POLL_LIMIT = 400;
    localparam int BURST_N    = `SPI_TX_DEPTH + 1;

    logic                  I_wb_clk = 1'b0;
    logic                  rst_n;
    logic                  wb_stb;
    logic                  wb_we;
    spi_wb_pkg::spi_reg_e  wb_adr;
    spi_wb_pkg::spi_byte_t wb_wdata;
    spi_wb_pkg::spi_byte_t wb_rdata;
    logic                  wb_ack;
    logic                  spi_miso = 1'b0;
    logic                  spi_sclk;
    logic                  spi_mosi;
    logic [2:0]            spi_cs_n;

    integer seed        = 32'hd303_821a;
    int     err_cnt     = 0;
    int     timeout_cnt = 0;

    // slave model takes the responses queued by the tests in order
    spi_wb_pkg::spi_byte_t resp_mem [32];
    int                    resp_wr   = 0;
    int                    resp_rd   = 0;
    spi_wb_pkg::spi_byte_t resp      = '0;
    spi_wb_pkg::spi_byte_t cap       = '0;
    int                    bit_n     = 0;
    spi_wb_pkg::spi_byte_t cap_mem [32];
    int                    cap_n     = 0;
    logic                  sclk_prev = 1'b0;
    logic [2:0]            cs_prev   = 3'b111;
    logic                  rise;
    logic                  fall;
    logic                  cs_fall;

    spi_wb_pkg::spi_byte_t burst_tx [BURST_N];
    spi_wb_pkg::spi_byte_t burst_rsp [BURST_N];
    int                    burst_start;

    spi_wb8 u_spi_wb8 (
        .I_wb_clk (I_wb_clk),
        .rst_n    (rst_n),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .spi_miso (spi_miso),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_cs_n (spi_cs_n)
    );

    always #2 I_wb_clk = ~I_wb_clk;

    task automatic next_response;
        if (resp_rd < resp_wr) begin
            resp = resp_mem[resp_rd];
            resp_rd++;
        end else begin
            resp = '0;
        end
    endtask

    always @(posedge spi_sclk or negedge spi_sclk or negedge spi_cs_n[0] or
             negedge spi_cs_n[1] or negedge spi_cs_n[2]) begin
        rise      = spi_sclk && !sclk_prev;
        fall      = !spi_sclk && sclk_prev;
        cs_fall   = (cs_prev & ~spi_cs_n) != 3'b000;
        sclk_prev = spi_sclk;
        cs_prev   = spi_cs_n;
        if (rise) begin
            cap = {cap[6:0], spi_mosi};
            bit_n++;
            if (bit_n == 8) begin
                cap_mem[cap_n] = cap;
                cap_n++;
                bit_n = 0;
                next_response();
            end
        end
        if (cs_fall) begin
            bit_n = 0;
            next_response();
        end
        // miso moves on the falling clock edge away from the sampling edge
        if (fall || cs_fall) begin
            @(negedge I_wb_clk);
            spi_miso = resp[7 - bit_n];
        end
    end

    task automatic check_byte(input string name, input spi_wb_pkg::spi_byte_t got,
                              input spi_wb_pkg::spi_byte_t want);
        if (got !== want) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_cs(input string name, input spi_wb_pkg::spi_cs_t got,
                            input spi_wb_pkg::spi_cs_t want);
        if (got !== want) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_cs_pins(input logic [2:0] got, input logic [2:0] want);
        if (got !== want) begin
            $display("FAIL spi_cs_n: got 0x%h, expected 0x%h", got, want);
            err_cnt++;
        end
    endtask

    // one strobe cycle with the ack expected on the next falling edge
    task automatic bus_access(input logic we, input spi_wb_pkg::spi_reg_e adr,
                              input spi_wb_pkg::spi_byte_t data);
        int n;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = data;
        @(negedge I_wb_clk);
        wb_stb = 1'b0;
        n = 0;
        while (!wb_ack && n < 8) begin
            @(negedge I_wb_clk);
            n++;
        end
        if (!wb_ack) begin
            $display("no ack within 8 cycles of a strobe");
            err_cnt++;
        end else if (n != 0) begin
            $display("ack came %0d cycles later than one cycle after the strobe", n);
            err_cnt++;
        end
    endtask

    task automatic bus_write(input spi_wb_pkg::spi_reg_e adr, input spi_wb_pkg::spi_byte_t data);
        bus_access(1'b1, adr, data);
    endtask

    task automatic bus_read(input spi_wb_pkg::spi_reg_e adr,
                            output spi_wb_pkg::spi_byte_t data);
        bus_access(1'b0, adr, 8'h00);
        data = wb_rdata;
    endtask

    // give the pushed byte time to reach the engine before polling
    task automatic wait_idle;
        spi_wb_pkg::spi_byte_t st;
        int n;
        repeat (2) @(negedge I_wb_clk);
        n  = 0;
        st = '0;
        while (!st[0] && n < POLL_LIMIT) begin
            bus_read(spi_wb_pkg::SPI_REG_STATUS, st);
            n++;
        end
        if (!st[0]) begin
            $display("status never showed idle after %0d polls", POLL_LIMIT);
            err_cnt++;
        end
    endtask

    task automatic transfer(input spi_wb_pkg::spi_cs_t dev, input spi_wb_pkg::spi_byte_t tx,
                            input spi_wb_pkg::spi_byte_t rx);
        spi_wb_pkg::spi_byte_t d;
        int start;
        bus_write(spi_wb_pkg::SPI_REG_CS, 8'h00);
        resp_mem[resp_wr] = rx;
        resp_wr++;
        bus_write(spi_wb_pkg::SPI_REG_CS, {6'b0, dev});
        start = cap_n;
        bus_write(spi_wb_pkg::SPI_REG_DATA, tx);
        wait_idle();
        if (cap_n != start + 1) begin
            $display("slave received %0d bytes instead of one", cap_n - start);
            err_cnt++;
        end
        check_byte("spi_mosi byte", cap_mem[start], tx);
        bus_read(spi_wb_pkg::SPI_REG_DATA, d);
        check_byte("wb_rdata (data)", d, rx);
    endtask

    task automatic test_reset;
        spi_wb_pkg::spi_byte_t d;
        bus_read(spi_wb_pkg::SPI_REG_STATUS, d);
        check_byte("wb_rdata (status)", d, 8'h01);
        bus_read(spi_wb_pkg::SPI_REG_CS, d);
        check_cs("wb_rdata (cs)", spi_wb_pkg::spi_cs_t'(d[1:0]), 2'd0);
        check_cs_pins(spi_cs_n, 3'b111);
        if (spi_sclk !== 1'b0) begin
            $display("FAIL spi_sclk: got 0x%h, expected 0x0", spi_sclk);
            err_cnt++;
        end
    endtask

    task automatic test_chip_select;
        int i;
        spi_wb_pkg::spi_byte_t d;
        logic [2:0] pins;
        for (i = 0; i < 4; i++) begin
            bus_write(spi_wb_pkg::SPI_REG_CS, 8'(i));
            bus_read(spi_wb_pkg::SPI_REG_CS, d);
            check_cs("wb_rdata (cs)", spi_wb_pkg::spi_cs_t'(d[1:0]), spi_wb_pkg::spi_cs_t'(i));
            pins = (i == 0) ? 3'b111 : ~(3'b001 << (i - 1));
            check_cs_pins(spi_cs_n, pins);
        end
        bus_write(spi_wb_pkg::SPI_REG_CS, 8'h00);
    endtask

    task automatic test_burst;
        int i;
        spi_wb_pkg::spi_byte_t d;
        bus_write(spi_wb_pkg::SPI_REG_CS, 8'h00);
        for (i = 0; i < BURST_N; i++) begin
            burst_rsp[i] = 8'($random(seed));
            resp_mem[resp_wr] = burst_rsp[i];
            resp_wr++;
        end
        bus_write(spi_wb_pkg::SPI_REG_CS, 8'h03);
        burst_start = cap_n;
        for (i = 0; i < BURST_N; i++) begin
            burst_tx[i] = 8'($random(seed));
            bus_write(spi_wb_pkg::SPI_REG_DATA, burst_tx[i]);
        end
        // last push lands in the buffer one cycle after its ack
        @(negedge I_wb_clk);
        bus_read(spi_wb_pkg::SPI_REG_STATUS, d);
        check_byte("wb_rdata (status)", d, 8'h02);
    endtask

    task automatic test_overflow;
        int i;
        spi_wb_pkg::spi_byte_t d;
        bus_write(spi_wb_pkg::SPI_REG_DATA, ~burst_tx[BURST_N-1]);
        wait_idle();
        if (cap_n - burst_start != BURST_N) begin
            $display("slave received %0d burst bytes, expected %0d", cap_n - burst_start, BURST_N);
            err_cnt++;
        end
        for (i = 0; i < BURST_N; i++) begin
            check_byte("spi_mosi byte", cap_mem[burst_start + i], burst_tx[i]);
        end
        bus_read(spi_wb_pkg::SPI_REG_DATA, d);
        check_byte("wb_rdata (data)", d, burst_rsp[BURST_N-1]);
        bus_write(spi_wb_pkg::SPI_REG_CS, 8'h00);
    endtask

    task automatic test_loopback;
        int i;
        spi_wb_pkg::spi_byte_t tx;
        spi_wb_pkg::spi_byte_t rx;
        for (i = 0; i < 10; i++) begin
            tx = 8'($random(seed));
            rx = 8'($random(seed));
            transfer(spi_wb_pkg::spi_cs_t'(i % 3 + 1), tx, rx);
        end
    endtask

    task automatic finish_run;
        $display("errors: %0d from checks, %0d from timeout", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = spi_wb_pkg::SPI_REG_DATA;
        wb_wdata = '0;
        repeat (4) @(negedge I_wb_clk);
        rst_n = 1'b1;
        test_reset();
        test_chip_select();
        // single transfer to device 2
        transfer(2'd2, 8'hc3, 8'h5a);
        test_burst();
        test_overflow();
        test_loopback();
        finish_run();
    end

    initial begin
        #(TIMEOUT_NS);
        timeout_cnt = 1;
        $display("run timed out after %0d ns", TIMEOUT_NS);
        finish_run();
    end

endmodule
